/* verilog/xgmii_pkg.sv */
package xgmii_pkg;

    // 64-bit XGMII, one control bit per byte lane
    localparam int XGMII_DATA_W = 64;
    localparam int XGMII_CTRL_W = 8;

    // control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    // start is only legal in lane 0
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // ethernet preamble bytes carried in the start word
    localparam logic [7:0] ETH_PREAMBLE = 8'h55;
    localparam logic [7:0] ETH_SFD      = 8'hd5;

    // pipeline latencies in clk cycles
    // rx word in to beat out
    localparam int RX_DECODE_LAT = 2;
    // beat in to beat out
    localparam int SWAP_LAT = 2;
    // beat in to tx word out
    localparam int TX_ENCODE_LAT = 2;

    // rx word to tx word through the whole core
    localparam int CORE_LAT = RX_DECODE_LAT + SWAP_LAT + TX_ENCODE_LAT;

endpackage

/* verilog/xgmii_rx_decode.sv */
`timescale 1ns/1ps

module xgmii_rx_decode
    import xgmii_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [XGMII_DATA_W-1:0] xgmii_rxd,
    input  logic [XGMII_CTRL_W-1:0] xgmii_rxc,
    output logic [XGMII_DATA_W-1:0] rx_data,
    output logic [XGMII_CTRL_W-1:0] rx_keep,
    output logic                    rx_valid,
    output logic                    rx_first,
    output logic                    rx_last,
    output logic                    rx_error
);

    localparam int LANE_W = $clog2(XGMII_CTRL_W);
    localparam logic [XGMII_DATA_W-1:0] START_WORD =
        {ETH_SFD, {6{ETH_PREAMBLE}}, XGMII_START};
    localparam logic [XGMII_CTRL_W-1:0] START_CTRL = XGMII_CTRL_W'(1);
    localparam logic [XGMII_DATA_W-1:0] IDLE_WORD = {XGMII_CTRL_W{XGMII_IDLE}};

    logic              in_frame;
    logic              first_pending;
    logic [LANE_W-1:0] ctrl_lane;
    logic              ctrl_found;
    logic              err_char;
    logic              term_ok;
    logic              is_idle;
    logic              is_start;
    logic              frame_end;
    logic              beat_in;
    logic              word_err;

    // held word, one cycle behind the input
    logic                    s1_valid;
    logic [XGMII_DATA_W-1:0] s1_data;
    logic [XGMII_CTRL_W-1:0] s1_keep;
    logic                    s1_first;
    logic                    s1_last;

    // lowest control lane, and any error character in a control lane
    always_comb begin
        ctrl_lane  = '0;
        ctrl_found = 1'b0;
        err_char   = 1'b0;
        for (int i = 0; i < XGMII_CTRL_W; i++) begin
            if (xgmii_rxc[i] && !ctrl_found) begin
                ctrl_lane  = LANE_W'(i);
                ctrl_found = 1'b1;
            end
            if (xgmii_rxc[i] && xgmii_rxd[8*i +: 8] == XGMII_ERROR) begin
                err_char = 1'b1;
            end
        end
        // terminate must be followed by idle control bytes only
        term_ok = ctrl_found && (xgmii_rxd[8*ctrl_lane +: 8] == XGMII_TERM);
        for (int i = 0; i < XGMII_CTRL_W; i++) begin
            if (i > int'(ctrl_lane) &&
                (!xgmii_rxc[i] || xgmii_rxd[8*i +: 8] != XGMII_IDLE)) begin
                term_ok = 1'b0;
            end
        end
    end

    assign is_idle  = (&xgmii_rxc) && (xgmii_rxd == IDLE_WORD);
    assign is_start = (xgmii_rxc == START_CTRL) && (xgmii_rxd == START_WORD);

    // any control inside a frame ends it, by terminate or by abort
    assign frame_end = in_frame && ctrl_found;
    // full data word, or terminate word that still carries data bytes
    assign beat_in   = in_frame && (!ctrl_found || (term_ok && ctrl_lane != '0));
    assign word_err  = err_char ||
                       (in_frame ? (ctrl_found && !term_ok) : !(is_idle || is_start));

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame      <= 1'b0;
            first_pending <= 1'b0;
            s1_valid      <= 1'b0;
            rx_valid      <= 1'b0;
            rx_error      <= 1'b0;
        end else begin
            if (!in_frame) begin
                in_frame      <= is_start;
                first_pending <= is_start;
            end else begin
                in_frame <= !ctrl_found;
                if (beat_in) begin
                    first_pending <= 1'b0;
                end
            end
            s1_valid <= beat_in;
            rx_valid <= s1_valid;
            rx_error <= word_err;
        end
    end

    always_ff @(posedge clk) begin
        s1_data  <= xgmii_rxd;
        // keep is the data lanes below terminate, all ones for a data word
        s1_keep  <= ~xgmii_rxc;
        s1_first <= first_pending;
        s1_last  <= frame_end;
        rx_data  <= s1_data;
        rx_keep  <= s1_keep;
        rx_first <= s1_first;
        // terminate in lane 0 (or an abort) makes the held beat the last one
        rx_last  <= s1_last || (frame_end && !beat_in);
    end

endmodule

/* verilog/mac_swap.sv */
`timescale 1ns/1ps

module mac_swap
    import xgmii_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [XGMII_DATA_W-1:0] rx_data,
    input  logic [XGMII_CTRL_W-1:0] rx_keep,
    input  logic                    rx_valid,
    input  logic                    rx_first,
    input  logic                    rx_last,
    output logic [XGMII_DATA_W-1:0] sw_data,
    output logic [XGMII_CTRL_W-1:0] sw_keep,
    output logic                    sw_valid,
    output logic                    sw_first,
    output logic                    sw_last,
    output logic                    frame_done
);

    logic [1:0] beat_cnt;
    logic [1:0] beat_idx;
    logic       swap_now;

    // first pipeline stage
    logic                    a_valid;
    logic [XGMII_DATA_W-1:0] a_data;
    logic [XGMII_CTRL_W-1:0] a_keep;
    logic                    a_first;
    logic                    a_last;

    logic [XGMII_DATA_W-1:0] b0_swapped;
    logic [XGMII_DATA_W-1:0] b1_swapped;

    // index of the incoming beat in its frame, saturates at 2
    assign beat_idx = rx_first ? 2'd0 : beat_cnt;

    // beat 1 arrives while beat 0 still sits in stage a
    assign swap_now = rx_valid && a_valid && (beat_idx == 2'd1);

    // frame bytes 0..5 trade places with bytes 6..11
    // beat 0 gets src (6,7 from itself, 8..11 from beat 1) then dst bytes 0,1
    assign b0_swapped = {a_data[15:0], rx_data[31:0], a_data[63:48]};
    // beat 1 lanes 0..3 get dst bytes 2..5, upper lanes untouched
    assign b1_swapped = {rx_data[63:32], a_data[47:16]};

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= 2'd0;
            a_valid    <= 1'b0;
            sw_valid   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            if (rx_valid) begin
                if (rx_last) begin
                    beat_cnt <= 2'd0;
                end else if (beat_idx != 2'd2) begin
                    beat_cnt <= beat_idx + 2'd1;
                end
            end
            a_valid    <= rx_valid;
            sw_valid   <= a_valid;
            frame_done <= a_valid && a_last;
        end
    end

    always_ff @(posedge clk) begin
        a_data   <= swap_now ? b1_swapped : rx_data;
        a_keep   <= rx_keep;
        a_first  <= rx_first;
        a_last   <= rx_last;
        sw_data  <= swap_now ? b0_swapped : a_data;
        sw_keep  <= a_keep;
        sw_first <= a_first;
        sw_last  <= a_last;
    end

endmodule

/* verilog/xgmii_tx_encode.sv */
`timescale 1ns/1ps

module xgmii_tx_encode
    import xgmii_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [XGMII_DATA_W-1:0] sw_data,
    input  logic [XGMII_CTRL_W-1:0] sw_keep,
    input  logic                    sw_valid,
    input  logic                    sw_first,
    input  logic                    sw_last,
    output logic [XGMII_DATA_W-1:0] xgmii_txd,
    output logic [XGMII_CTRL_W-1:0] xgmii_txc
);

    localparam logic [XGMII_DATA_W-1:0] START_WORD =
        {ETH_SFD, {6{ETH_PREAMBLE}}, XGMII_START};
    localparam logic [XGMII_CTRL_W-1:0] START_CTRL = XGMII_CTRL_W'(1);
    localparam logic [XGMII_DATA_W-1:0] IDLE_WORD = {XGMII_CTRL_W{XGMII_IDLE}};
    localparam logic [XGMII_DATA_W-1:0] TERM_WORD =
        {{(XGMII_CTRL_W-1){XGMII_IDLE}}, XGMII_TERM};

    // holding register, one beat
    logic                    h_valid;
    logic [XGMII_DATA_W-1:0] h_data;
    logic [XGMII_CTRL_W-1:0] h_keep;
    logic                    h_last;

    // full last beat owes a terminate word
    logic term_pending;

    logic [XGMII_DATA_W-1:0] enc_d;
    logic [XGMII_CTRL_W-1:0] enc_c;
    logic                    prev_kept;

    // kept lanes carry data, the first empty lane gets terminate, idle after it
    always_comb begin
        enc_d     = IDLE_WORD;
        enc_c     = '1;
        prev_kept = 1'b1;
        for (int i = 0; i < XGMII_CTRL_W; i++) begin
            if (h_keep[i]) begin
                enc_d[8*i +: 8] = h_data[8*i +: 8];
                enc_c[i]        = 1'b0;
            end else if (prev_kept) begin
                enc_d[8*i +: 8] = XGMII_TERM;
            end
            prev_kept = h_keep[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_valid      <= 1'b0;
            term_pending <= 1'b0;
            xgmii_txd    <= IDLE_WORD;
            xgmii_txc    <= '1;
        end else begin
            h_valid      <= sw_valid;
            term_pending <= h_valid && h_last && (&h_keep);
            if (h_valid) begin
                xgmii_txd <= enc_d;
                xgmii_txc <= enc_c;
            end else if (term_pending) begin
                xgmii_txd <= TERM_WORD;
                xgmii_txc <= '1;
            end else if (sw_valid && sw_first) begin
                // start goes out while the first beat waits in the holding register
                xgmii_txd <= START_WORD;
                xgmii_txc <= START_CTRL;
            end else begin
                xgmii_txd <= IDLE_WORD;
                xgmii_txc <= '1;
            end
        end
    end

    always_ff @(posedge clk) begin
        h_data <= sw_data;
        h_keep <= sw_keep;
        h_last <= sw_last;
    end

endmodule

/* verilog/link_status.sv */
`timescale 1ns/1ps

module link_status #(
    parameter int COUNT_W = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       frame_done,
    input  logic       rx_error,
    output logic [3:0] user_led
);

    logic [COUNT_W-1:0] frame_cnt;
    logic               err_flag;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
            err_flag  <= 1'b0;
        end else begin
            // counter wraps freely
            if (frame_done) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            // sticky until reset
            if (rx_error) begin
                err_flag <= 1'b1;
            end
        end
    end

    // error on the top led, frame count below it
    assign user_led = {err_flag, frame_cnt};

endmodule

/* verilog/reflector_core.sv */
`timescale 1ns/1ps

module reflector_core
    import xgmii_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [XGMII_DATA_W-1:0] xgmii_rxd,
    input  logic [XGMII_CTRL_W-1:0] xgmii_rxc,
    output logic [XGMII_DATA_W-1:0] xgmii_txd,
    output logic [XGMII_CTRL_W-1:0] xgmii_txc,
    output logic [3:0]              user_led
);

    // three led bits for the frame count
    localparam int FRAME_COUNT_W = 3;

    logic [XGMII_DATA_W-1:0] rx_data;
    logic [XGMII_CTRL_W-1:0] rx_keep;
    logic                    rx_valid;
    logic                    rx_first;
    logic                    rx_last;
    logic                    rx_error;

    logic [XGMII_DATA_W-1:0] sw_data;
    logic [XGMII_CTRL_W-1:0] sw_keep;
    logic                    sw_valid;
    logic                    sw_first;
    logic                    sw_last;
    logic                    frame_done;

    xgmii_rx_decode rx_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .xgmii_rxd (xgmii_rxd),
        .xgmii_rxc (xgmii_rxc),
        .rx_data   (rx_data),
        .rx_keep   (rx_keep),
        .rx_valid  (rx_valid),
        .rx_first  (rx_first),
        .rx_last   (rx_last),
        .rx_error  (rx_error)
    );

    mac_swap mac_swap_inst (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_keep    (rx_keep),
        .rx_valid   (rx_valid),
        .rx_first   (rx_first),
        .rx_last    (rx_last),
        .sw_data    (sw_data),
        .sw_keep    (sw_keep),
        .sw_valid   (sw_valid),
        .sw_first   (sw_first),
        .sw_last    (sw_last),
        .frame_done (frame_done)
    );

    xgmii_tx_encode tx_encode_inst (
        .clk       (clk),
        .rst       (rst),
        .sw_data   (sw_data),
        .sw_keep   (sw_keep),
        .sw_valid  (sw_valid),
        .sw_first  (sw_first),
        .sw_last   (sw_last),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

    link_status #(
        .COUNT_W (FRAME_COUNT_W)
    ) link_status_inst (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .rx_error   (rx_error),
        .user_led   (user_led)
    );

endmodule

/* testbench/reflector_props.sv */
`timescale 1ns/1ps

module reflector_props
    import xgmii_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input logic [XGMII_CTRL_W-1:0] sw_keep,
    input logic                    sw_valid,
    input logic                    sw_first,
    input logic                    sw_last,
    input logic                    frame_done
);

    bit  first_fail;
    bit  gap_fail;
    bit  keep_fail;
    bit  done_fail;
    logic any_fail;

    assign any_fail = first_fail | gap_fail | keep_fail | done_fail;

    first_needs_valid: assert property (@(posedge clk) disable iff (rst)
        sw_first |-> sw_valid)
    else begin
        first_fail = 1'b1;
        $error("sw_first set without sw_valid");
    end

    // beats of one frame come on back-to-back cycles
    no_gap_in_frame: assert property (@(posedge clk) disable iff (rst)
        sw_valid && !sw_last |=> sw_valid)
    else begin
        gap_fail = 1'b1;
        $error("valid beat without sw_last not followed by a valid beat");
    end

    full_keep_mid_frame: assert property (@(posedge clk) disable iff (rst)
        sw_valid && !sw_last |-> &sw_keep)
    else begin
        keep_fail = 1'b1;
        $error("partial sw_keep on a beat that is not the last");
    end

    done_with_last: assert property (@(posedge clk) disable iff (rst)
        frame_done == (sw_valid && sw_last))
    else begin
        done_fail = 1'b1;
        $error("frame_done does not match the outgoing last beat");
    end

endmodule

bind mac_swap reflector_props props0 (
    .clk        (clk),
    .rst        (rst),
    .sw_keep    (sw_keep),
    .sw_valid   (sw_valid),
    .sw_first   (sw_first),
    .sw_last    (sw_last),
    .frame_done (frame_done)
);

/* testbench/reflector_tb.sv */
`timescale 1ns/1ps

module reflector_tb
    import xgmii_pkg::*;
();

    localparam int WORD_W = XGMII_CTRL_W + XGMII_DATA_W;
    localparam int MAX_LEN = 40;
    localparam int N_ITEMS = 13;
    localparam int DRAIN_TIMEOUT = 50;
    localparam logic [XGMII_DATA_W-1:0] IDLE_D = {XGMII_CTRL_W{XGMII_IDLE}};
    localparam logic [XGMII_CTRL_W-1:0] IDLE_C = '1;
    localparam logic [XGMII_DATA_W-1:0] START_D = {ETH_SFD, {6{ETH_PREAMBLE}}, XGMII_START};
    localparam logic [XGMII_CTRL_W-1:0] START_C = XGMII_CTRL_W'(1);
    // error character in lane 3, idle in the other lanes
    localparam logic [XGMII_DATA_W-1:0] ERR_D = {{4{XGMII_IDLE}}, XGMII_ERROR, {3{XGMII_IDLE}}};

    logic                    clk;
    logic                    rst;
    logic [XGMII_DATA_W-1:0] xgmii_rxd;
    logic [XGMII_CTRL_W-1:0] xgmii_rxc;
    logic [XGMII_DATA_W-1:0] xgmii_txd;
    logic [XGMII_CTRL_W-1:0] xgmii_txc;
    logic [3:0]              user_led;

    // frame length in bytes, 0 stands for a single error word
    // terminate lanes: 0 1 2 3 4 - 5 6 7 0 0 1 7
    int item_len [N_ITEMS] = '{16, 25, 34, 19, 28, 0, 37, 22, 31, 40, 24, 17, 23};
    // idle words after each item
    int item_gap [N_ITEMS] = '{2, 2, 3, 2, 2, 4, 2, 2, 4, 2, 2, 2, 6};

    // expected tx words, one per driven rx word
    logic [XGMII_DATA_W-1:0] exp_d_q [$];
    logic [XGMII_CTRL_W-1:0] exp_c_q [$];
    logic [XGMII_DATA_W-1:0] exp_d_now;
    logic [XGMII_CTRL_W-1:0] exp_c_now;

    logic [7:0]  frame_bytes [MAX_LEN];
    logic [7:0]  swap_bytes [MAX_LEN];
    logic [15:0] lfsr;
    bit          check_en;
    bit          err_sent;
    int          frames_sent;

    reflector_core dut0 (
        .clk       (clk),
        .rst       (rst),
        .xgmii_rxd (xgmii_rxd),
        .xgmii_rxc (xgmii_rxc),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc),
        .user_led  (user_led)
    );

    always #4 clk = ~clk;

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // word w of a frame body: data below len, terminate at len, idle above
    function automatic logic [WORD_W-1:0] body_word(
        input logic [7:0] bytes [MAX_LEN],
        input int         len,
        input int         w
    );
        logic [XGMII_DATA_W-1:0] d;
        logic [XGMII_CTRL_W-1:0] c;
        int                      idx;
        for (int i = 0; i < XGMII_CTRL_W; i++) begin
            idx = 8 * w + i;
            if (idx < len) begin
                d[8*i +: 8] = bytes[idx];
                c[i]        = 1'b0;
            end else if (idx == len) begin
                d[8*i +: 8] = XGMII_TERM;
                c[i]        = 1'b1;
            end else begin
                d[8*i +: 8] = XGMII_IDLE;
                c[i]        = 1'b1;
            end
        end
        return {c, d};
    endfunction

    task automatic report_mismatch(
        input string             what,
        input logic [WORD_W-1:0] expv,
        input logic [WORD_W-1:0] actv
    );
        $display("[ERROR] %0t: %s mismatch, expected %h, got %h", $time, what, expv, actv);
        $display(">>> FAIL");
        $fatal(1, "output mismatch");
    endtask

    task automatic drive_word(
        input logic [XGMII_DATA_W-1:0] d,
        input logic [XGMII_CTRL_W-1:0] c,
        input logic [XGMII_DATA_W-1:0] ed,
        input logic [XGMII_CTRL_W-1:0] ec
    );
        @(posedge clk);
        xgmii_rxd <= d;
        xgmii_rxc <= c;
        exp_d_q.push_back(ed);
        exp_c_q.push_back(ec);
    endtask

    task automatic send_idle(input int n);
        for (int i = 0; i < n; i++) begin
            drive_word(IDLE_D, IDLE_C, IDLE_D, IDLE_C);
        end
    endtask

    task automatic send_frame(input int len);
        logic [7:0]        b;
        logic [WORD_W-1:0] in_w;
        logic [WORD_W-1:0] out_w;
        for (int k = 0; k < len; k++) begin
            b = '0;
            for (int j = 0; j < 8; j++) begin
                lfsr = lfsr_next(lfsr);
                b    = {b[6:0], lfsr[0]};
            end
            frame_bytes[k] = b;
        end
        // destination and source addresses trade places
        for (int k = 0; k < len; k++) begin
            if (k < 6) begin
                swap_bytes[k] = frame_bytes[k + 6];
            end else if (k < 12) begin
                swap_bytes[k] = frame_bytes[k - 6];
            end else begin
                swap_bytes[k] = frame_bytes[k];
            end
        end
        drive_word(START_D, START_C, START_D, START_C);
        for (int w = 0; w <= len / 8; w++) begin
            in_w  = body_word(frame_bytes, len, w);
            out_w = body_word(swap_bytes, len, w);
            drive_word(in_w[XGMII_DATA_W-1:0], in_w[WORD_W-1 -: XGMII_CTRL_W],
                       out_w[XGMII_DATA_W-1:0], out_w[WORD_W-1 -: XGMII_CTRL_W]);
        end
    endtask

    task automatic check_leds(input logic [3:0] expv, input logic [3:0] mask);
        @(negedge clk);
        assert ((user_led & mask) === (expv & mask))
        else report_mismatch("user_led", WORD_W'(expv & mask), WORD_W'(user_led & mask));
    endtask

    // output word against the model entry from CORE_LAT cycles earlier
    always @(negedge clk) begin
        if (check_en && exp_d_q.size() > 0) begin
            exp_d_now = exp_d_q.pop_front();
            exp_c_now = exp_c_q.pop_front();
            assert (xgmii_txd === exp_d_now && xgmii_txc === exp_c_now)
            else report_mismatch("tx word", {exp_c_now, exp_d_now}, {xgmii_txc, xgmii_txd});
        end
    end

    initial begin
        int waited;
        clk         = 1'b0;
        rst         = 1'b1;
        xgmii_rxd   = IDLE_D;
        xgmii_rxc   = IDLE_C;
        lfsr        = 16'd2;
        check_en    = 1'b0;
        err_sent    = 1'b0;
        frames_sent = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // the pipeline comes out of reset with idle words in flight
        for (int i = 0; i < CORE_LAT; i++) begin
            exp_d_q.push_back(IDLE_D);
            exp_c_q.push_back(IDLE_C);
        end
        drive_word(IDLE_D, IDLE_C, IDLE_D, IDLE_C);
        check_en = 1'b1;
        send_idle(3);
        check_leds(4'h0, 4'hf);
        for (int n = 0; n < N_ITEMS; n++) begin
            if (item_len[n] == 0) begin
                // error word is dropped and comes out as idle
                drive_word(ERR_D, IDLE_C, IDLE_D, IDLE_C);
                err_sent = 1'b1;
            end else begin
                send_frame(item_len[n]);
                frames_sent++;
            end
            send_idle(item_gap[n]);
            check_leds({err_sent, 3'b000}, 4'h8);
        end
        waited = 0;
        while (exp_d_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_d_q.size() != 0) begin
            $display("Timed out waiting for the TX output to drain");
            $display(">>> FAIL");
            $fatal(1, "drain timeout");
        end
        check_leds({err_sent, frames_sent[2:0]}, 4'hf);
        if (!dut0.mac_swap_inst.props0.any_fail) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("A beat stream assertion failed during the run");
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
    end

endmodule

/* compile.f */
verilog/xgmii_pkg.sv
verilog/xgmii_rx_decode.sv
verilog/mac_swap.sv
verilog/xgmii_tx_encode.sv
verilog/link_status.sv
verilog/reflector_core.sv
testbench/reflector_props.sv
testbench/reflector_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = reflector_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
